/* verilog/conv_pkg.sv */
`default_nettype none

package conv_pkg;

    // **********************************************************************
    // fixed-point format and widths
    // **********************************************************************
    localparam int PIX_W    = 20;   // signed 4.16
    localparam int FRAC_W   = 16;
    localparam int ACC_W    = 40;   // full width of a 20x20 product sum
    localparam int ADDR_W   = 12;   // memory port width, fixed
    localparam int NUM_TAPS = 9;    // 3x3 window

    typedef logic signed [PIX_W-1:0] pix_t;

    // **********************************************************************
    // kernels, row major from top-left tap
    // **********************************************************************
    localparam pix_t KERNEL_W [0:1][0:NUM_TAPS-1] = '{
        '{
            20'h0A89E, 20'h092D5, 20'h06D43,
            20'h01004, 20'hF8F71, 20'hF6E54,
            20'hFA6D7, 20'hFC834, 20'hFAC19
        },
        '{
            20'hFDB55, 20'h02992, 20'hFC994,
            20'h050FD, 20'h02F20, 20'h0202D,
            20'h03BD7, 20'hFD369, 20'h05E68
        }
    };

    // kernel 1 bias is negative
    localparam pix_t KERNEL_BIAS [0:1] = '{20'h01310, 20'hF7295};

    // result memory selects
    localparam logic [2:0] SEL_NONE  = 3'd0;
    localparam logic [2:0] SEL_L0_K0 = 3'd1;   // layer 0, kernel 0 map
    localparam logic [2:0] SEL_L0_K1 = 3'd2;
    localparam logic [2:0] SEL_L1_K0 = 3'd3;   // pooled maps
    localparam logic [2:0] SEL_L1_K1 = 3'd4;

    // **********************************************************************
    // streams between blocks
    // **********************************************************************

    // one window tap, shared by both MACs
    typedef struct packed {
        pix_t       pixel;   // zero when outside the image
        logic [3:0] index;   // 0..8, selects the weight
        logic       valid;
        logic       first;   // tap 0, clears accumulator
        logic       last;    // tap 8, bias and round
    } tap_t;

    // one pooled result headed for layer 1
    typedef struct packed {
        pix_t              data;
        logic [ADDR_W-1:0] waddr;
        logic              kernel;
        logic              valid;
    } pool_t;

endpackage

`default_nettype wire

/* verilog/window_fetch.sv */
`default_nettype none

module window_fetch
    import conv_pkg::*;
#(
    parameter int IMG_BITS = 6
) (
    input  wire               clk,
    input  wire               rst,
    input  wire               fetch_en,
    input  wire               next_centre,
    input  wire pix_t         idata,
    output logic [ADDR_W-1:0] iaddr,
    output tap_t              tap,
    output logic              image_last
);

    localparam int OFF_W = IMG_BITS + 2;   // room for -1 and N
    localparam logic signed [OFF_W-1:0] OFF_M1 = '1;
    localparam logic signed [OFF_W-1:0] OFF_0  = '0;
    localparam logic signed [OFF_W-1:0] OFF_P1 = {{(OFF_W-1){1'b0}}, 1'b1};

    logic [2*IMG_BITS-1:0]   centre;    // {row, col}
    logic [3:0]              tap_cnt;
    logic                    running;   // inside an image pass
    logic [IMG_BITS-1:0]     row;
    logic [IMG_BITS-1:0]     col;
    logic signed [OFF_W-1:0] row_off;
    logic signed [OFF_W-1:0] col_off;
    logic signed [OFF_W-1:0] nrow;
    logic signed [OFF_W-1:0] ncol;
    logic                    pad;

    assign row = centre[2*IMG_BITS-1 -: IMG_BITS];
    assign col = centre[IMG_BITS-1:0];

    // neighbour offset from tap index
    always_comb begin
        case (tap_cnt)
            4'd0, 4'd1, 4'd2: row_off = OFF_M1;
            4'd3, 4'd4, 4'd5: row_off = OFF_0;
            default:          row_off = OFF_P1;
        endcase
        case (tap_cnt)
            4'd0, 4'd3, 4'd6: col_off = OFF_M1;
            4'd1, 4'd4, 4'd7: col_off = OFF_0;
            default:          col_off = OFF_P1;
        endcase
    end

    assign nrow = $signed({2'b00, row}) + row_off;
    assign ncol = $signed({2'b00, col}) + col_off;

    // -1 sets the sign bit, N sets bit IMG_BITS
    assign pad = nrow[OFF_W-1] | nrow[OFF_W-2] | ncol[OFF_W-1] | ncol[OFF_W-2];

    assign iaddr = pad ? '0 : ADDR_W'({nrow[IMG_BITS-1:0], ncol[IMG_BITS-1:0]});

    always_comb begin
        tap.pixel = (fetch_en && !pad) ? idata : '0;
        tap.index = tap_cnt;
        tap.valid = fetch_en;
        tap.first = fetch_en && (tap_cnt == 4'd0);
        tap.last  = fetch_en && (tap_cnt == 4'(NUM_TAPS - 1));
    end

    assign image_last = (centre == '1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tap_cnt <= '0;
        end else if (next_centre) begin
            tap_cnt <= '0;
        end else if (fetch_en) begin
            tap_cnt <= (tap_cnt == 4'(NUM_TAPS - 1)) ? '0 : tap_cnt + 4'd1;
        end
    end

    // centre is held at the origin between passes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            centre  <= '0;
            running <= 1'b0;
        end else begin
            if (!running)
                centre <= '0;
            else if (next_centre)
                centre <= centre + 1'b1;   // raster order

            if (next_centre && image_last)
                running <= 1'b0;
            else if (fetch_en)
                running <= 1'b1;
        end
    end

    a_iaddr_in_image: assert property (@(posedge clk) disable iff (rst)
        fetch_en |-> int'(iaddr) < (1 << (2 * IMG_BITS)));

    // centre may only move between fetch rounds
    a_advance_idle: assert property (@(posedge clk) disable iff (rst)
        next_centre |-> !fetch_en && tap_cnt == 4'd0);

endmodule

`default_nettype wire

/* verilog/conv_mac.sv */
`default_nettype none

module conv_mac
    import conv_pkg::*;
#(
    parameter int KERNEL_ID = 0
) (
    input  wire       clk,
    input  wire       rst,
    input  wire tap_t tap,
    output pix_t      result
);

    pix_t                    weight;
    pix_t                    bias;
    logic signed [ACC_W-1:0] bias_ext;
    logic signed [ACC_W-1:0] prod;
    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] sum;

    assign weight = KERNEL_W[KERNEL_ID][tap.index];
    assign bias   = KERNEL_BIAS[KERNEL_ID];

    // bias lined up with the product binary point
    assign bias_ext = {{(ACC_W-PIX_W-FRAC_W){bias[PIX_W-1]}}, bias, {FRAC_W{1'b0}}};

    assign prod = tap.pixel * weight;   // 8.32 product

    // first tap restarts the sum, last tap folds in the bias
    assign sum = (tap.first ? '0 : acc) + prod + (tap.last ? bias_ext : '0);

    // **********************************************************************
    // accumulate one tap per cycle
    // **********************************************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc    <= '0;
            result <= '0;
        end else if (tap.valid) begin
            acc <= sum;
            if (tap.last) begin
                // back to 4.16, round half up on bit 15
                result <= sum[FRAC_W +: PIX_W] + PIX_W'(sum[FRAC_W-1]);
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/max_pool.sv */
`default_nettype none

module max_pool
    import conv_pkg::*;
#(
    parameter int IMG_BITS = 6
) (
    input  wire               clk,
    input  wire               rst,
    input  wire               pool_en,
    input  wire pix_t         cdata_rd,
    output logic [ADDR_W-1:0] rd_addr,
    output logic              rd_kernel,
    output pool_t             pool,
    output logic              pool_last
);

    localparam int HB = IMG_BITS - 1;   // block row/col bits

    logic [2*HB-1:0] blk_idx;    // pooled write index, {blk_row, blk_col}
    logic [2:0]      rd_cnt;     // read within the 2x2 block
    logic            wr_phase;   // result cycle after 4 reads
    logic            kern;
    pix_t            max_q;
    logic [HB-1:0]   blk_row;
    logic [HB-1:0]   blk_col;

    assign blk_row = blk_idx[2*HB-1 -: HB];
    assign blk_col = blk_idx[HB-1:0];

    // row = 2*blk_row + dy, col = 2*blk_col + dx
    assign rd_addr   = ADDR_W'({blk_row, rd_cnt[1], blk_col, rd_cnt[0]});
    assign rd_kernel = kern;

    always_comb begin
        pool.data   = max_q;
        pool.waddr  = ADDR_W'(blk_idx);
        pool.kernel = kern;
        pool.valid  = pool_en && wr_phase;
    end

    assign pool_last = pool.valid && kern && (blk_idx == '1);

    // **********************************************************************
    // block walk: 4 reads + 1 write per kernel, kernel 0 first
    // **********************************************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_cnt   <= '0;
            wr_phase <= 1'b0;
            kern     <= 1'b0;
            blk_idx  <= '0;
        end else if (!pool_en) begin
            rd_cnt   <= '0;   // next pass starts at block 0
            wr_phase <= 1'b0;
            kern     <= 1'b0;
            blk_idx  <= '0;
        end else if (wr_phase) begin
            wr_phase <= 1'b0;
            kern     <= ~kern;
            if (kern)
                blk_idx <= blk_idx + 1'b1;
        end else if (rd_cnt == 3'd3) begin
            rd_cnt   <= '0;
            wr_phase <= 1'b1;
        end else begin
            rd_cnt <= rd_cnt + 3'd1;
        end
    end

    // signed running maximum
    always_ff @(posedge clk) begin
        if (pool_en && !wr_phase) begin
            if (rd_cnt == 3'd0 || cdata_rd > max_q)
                max_q <= cdata_rd;
        end
    end

    a_rd_cnt_range: assert property (@(posedge clk) disable iff (rst)
        rd_cnt <= 3'd3);

endmodule

`default_nettype wire

/* verilog/layer_ctrl.sv */
`default_nettype none

module layer_ctrl
    import conv_pkg::*;
(
    input  wire               clk,
    input  wire               rst,
    input  wire               ready,
    input  wire tap_t         tap,
    input  wire               image_last,
    input  wire pix_t         k0_result,
    input  wire pix_t         k1_result,
    input  wire pool_t        pool,
    input  wire               pool_last,
    input  wire [ADDR_W-1:0]  rd_addr,
    input  wire               rd_kernel,
    output logic              fetch_en,
    output logic              next_centre,
    output logic              pool_en,
    output logic              busy,
    output logic              cwr,
    output logic              crd,
    output logic [ADDR_W-1:0] caddr_wr,
    output logic [ADDR_W-1:0] caddr_rd,
    output pix_t              cdata_wr,
    output logic [2:0]        csel
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_WR_K0,
        ST_WR_K1,
        ST_POOL,
        ST_DONE
    } state_t;

    state_t            state;
    state_t            state_nxt;
    logic [ADDR_W-1:0] wr_addr;   // layer-0 centre index

    function automatic pix_t relu(input pix_t v);
        return v[PIX_W-1] ? '0 : v;
    endfunction

    // **********************************************************************
    // FSM
    // **********************************************************************
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:  if (ready) state_nxt = ST_FETCH;
            ST_FETCH: if (tap.last) state_nxt = ST_WR_K0;
            ST_WR_K0: state_nxt = ST_WR_K1;
            ST_WR_K1: state_nxt = image_last ? ST_POOL : ST_FETCH;
            ST_POOL:  if (pool_last) state_nxt = ST_DONE;
            ST_DONE:  state_nxt = ST_IDLE;
            default:  state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
            busy  <= 1'b0;
        end else begin
            state <= state_nxt;
            busy  <= (state_nxt != ST_IDLE) && (state_nxt != ST_DONE);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            wr_addr <= '0;
        else if (state == ST_IDLE)
            wr_addr <= '0;
        else if (state == ST_WR_K1)
            wr_addr <= wr_addr + 1'b1;   // both maps written
    end

    assign fetch_en    = (state == ST_FETCH);
    assign next_centre = (state == ST_WR_K1);
    assign pool_en     = (state == ST_POOL);

    // **********************************************************************
    // result memory port
    // **********************************************************************
    always_comb begin
        cwr      = 1'b0;
        crd      = 1'b0;
        csel     = SEL_NONE;
        caddr_wr = '0;
        caddr_rd = '0;
        cdata_wr = '0;
        case (state)
            ST_WR_K0: begin
                cwr      = 1'b1;
                csel     = SEL_L0_K0;
                caddr_wr = wr_addr;
                cdata_wr = relu(k0_result);
            end
            ST_WR_K1: begin
                cwr      = 1'b1;
                csel     = SEL_L0_K1;
                caddr_wr = wr_addr;
                cdata_wr = relu(k1_result);
            end
            ST_POOL: begin
                if (pool.valid) begin
                    cwr      = 1'b1;
                    csel     = pool.kernel ? SEL_L1_K1 : SEL_L1_K0;
                    caddr_wr = pool.waddr;
                    cdata_wr = pool.data;   // already non-negative
                end else begin
                    crd      = 1'b1;
                    csel     = rd_kernel ? SEL_L0_K1 : SEL_L0_K0;
                    caddr_rd = rd_addr;
                end
            end
            default: ;
        endcase
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
        !(cwr && crd));

    // no memory traffic outside a busy window
    a_quiet_when_idle: assert property (@(posedge clk) disable iff (rst)
        !busy |-> !cwr && !crd);

endmodule

`default_nettype wire

/* verilog/conv_top.sv */
`default_nettype none

module conv_top
    import conv_pkg::*;
#(
    parameter int IMG_BITS = 6   // log2 of image side
) (
    input  wire               clk,
    input  wire               rst,
    input  wire               ready,
    input  wire pix_t         idata,
    input  wire pix_t         cdata_rd,
    output logic              busy,
    output logic              cwr,
    output logic              crd,
    output logic [ADDR_W-1:0] iaddr,
    output logic [ADDR_W-1:0] caddr_wr,
    output logic [ADDR_W-1:0] caddr_rd,
    output pix_t              cdata_wr,
    output logic [2:0]        csel
);

    tap_t              tap;
    pix_t              k0_result;
    pix_t              k1_result;
    pool_t             pool;
    logic              fetch_en;
    logic              next_centre;
    logic              image_last;
    logic              pool_en;
    logic              pool_last;
    logic              rd_kernel;
    logic [ADDR_W-1:0] rd_addr;

    window_fetch #(
        .IMG_BITS (IMG_BITS)
    ) u_window_fetch (
        .clk         (clk),
        .rst         (rst),
        .fetch_en    (fetch_en),
        .next_centre (next_centre),
        .idata       (idata),
        .iaddr       (iaddr),
        .tap         (tap),
        .image_last  (image_last)
    );

    // both kernels see the same tap stream
    conv_mac #(
        .KERNEL_ID (0)
    ) u_mac_k0 (
        .clk    (clk),
        .rst    (rst),
        .tap    (tap),
        .result (k0_result)
    );

    conv_mac #(
        .KERNEL_ID (1)
    ) u_mac_k1 (
        .clk    (clk),
        .rst    (rst),
        .tap    (tap),
        .result (k1_result)
    );

    max_pool #(
        .IMG_BITS (IMG_BITS)
    ) u_max_pool (
        .clk       (clk),
        .rst       (rst),
        .pool_en   (pool_en),
        .cdata_rd  (cdata_rd),
        .rd_addr   (rd_addr),
        .rd_kernel (rd_kernel),
        .pool      (pool),
        .pool_last (pool_last)
    );

    layer_ctrl u_layer_ctrl (
        .clk         (clk),
        .rst         (rst),
        .ready       (ready),
        .tap         (tap),
        .image_last  (image_last),
        .k0_result   (k0_result),
        .k1_result   (k1_result),
        .pool        (pool),
        .pool_last   (pool_last),
        .rd_addr     (rd_addr),
        .rd_kernel   (rd_kernel),
        .fetch_en    (fetch_en),
        .next_centre (next_centre),
        .pool_en     (pool_en),
        .busy        (busy),
        .cwr         (cwr),
        .crd         (crd),
        .caddr_wr    (caddr_wr),
        .caddr_rd    (caddr_rd),
        .cdata_wr    (cdata_wr),
        .csel        (csel)
    );

endmodule

`default_nettype wire

/* dv/conv_tb.sv */
`default_nettype none

module conv_tb
    import conv_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int IMG_BITS     = 3;
    localparam int SIDE         = 1 << IMG_BITS;
    localparam int HALF         = SIDE / 2;
    localparam int NPIX         = SIDE * SIDE;
    localparam int NPOOL        = HALF * HALF;
    localparam int AW           = 2 * IMG_BITS;   // used address bits
    localparam int NUM_TESTS    = 5;
    localparam int BUSY_TIMEOUT = 5000;           // cycles, whole image pass

    localparam logic [2:0] PAT_ZERO    = 3'd0;
    localparam logic [2:0] PAT_CONST   = 3'd1;
    localparam logic [2:0] PAT_RAND    = 3'd2;
    localparam logic [2:0] PAT_CHECKER = 3'd3;

    typedef struct packed {
        logic [2:0] kind;
        pix_t       fill;
    } test_row_t;

    localparam test_row_t TESTS [0:NUM_TESTS-1] = '{
        '{PAT_ZERO,    20'h00000},
        '{PAT_CONST,   20'h10000},   // +1.0
        '{PAT_CONST,   20'hE8000},   // -1.5
        '{PAT_RAND,    20'h00000},
        '{PAT_CHECKER, 20'h18000}    // +-1.5
    };

    logic              clk;
    logic              rst;
    logic              ready;
    pix_t              idata;
    pix_t              cdata_rd;
    pix_t              cdata_wr;
    logic              busy;
    logic              cwr;
    logic              crd;
    logic [ADDR_W-1:0] iaddr;
    logic [ADDR_W-1:0] caddr_wr;
    logic [ADDR_W-1:0] caddr_rd;
    logic [2:0]        csel;

    pix_t   rom       [0:NPIX-1];
    pix_t   mem_l0_k0 [0:NPIX-1];   // memory 1
    pix_t   mem_l0_k1 [0:NPIX-1];   // memory 2
    pix_t   mem_l1_k0 [0:NPIX-1];   // memory 3
    pix_t   mem_l1_k1 [0:NPIX-1];   // memory 4
    pix_t   exp_k0    [0:NPIX-1];
    pix_t   exp_k1    [0:NPIX-1];
    pix_t   exp_p0    [0:NPOOL-1];
    pix_t   exp_p1    [0:NPOOL-1];
    logic   clear_mem;
    logic   timed_out;
    integer seed;
    int     errors;
    int     port_errors;
    int     failed_tests;
    int     tests_run;

    conv_top #(
        .IMG_BITS (IMG_BITS)
    ) u_conv_top (
        .clk      (clk),
        .rst      (rst),
        .ready    (ready),
        .idata    (idata),
        .cdata_rd (cdata_rd),
        .busy     (busy),
        .cwr      (cwr),
        .crd      (crd),
        .iaddr    (iaddr),
        .caddr_wr (caddr_wr),
        .caddr_rd (caddr_rd),
        .cdata_wr (cdata_wr),
        .csel     (csel)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // **********************************************************************
    // memory models
    // **********************************************************************
    assign idata = rom[iaddr[AW-1:0]];   // async image ROM

    always_comb begin
        cdata_rd = '0;
        if (crd) begin
            case (csel)
                SEL_L0_K0: cdata_rd = mem_l0_k0[caddr_rd[AW-1:0]];
                SEL_L0_K1: cdata_rd = mem_l0_k1[caddr_rd[AW-1:0]];
                SEL_L1_K0: cdata_rd = mem_l1_k0[caddr_rd[AW-1:0]];
                SEL_L1_K1: cdata_rd = mem_l1_k1[caddr_rd[AW-1:0]];
                default:   cdata_rd = '0;
            endcase
        end
    end

    always @(posedge clk) begin : mem_write
        int i;
        if (clear_mem) begin
            // negative marker, never a ReLU output
            for (i = 0; i < NPIX; i++) begin
                mem_l0_k0[i] <= 20'h80000 | PIX_W'(i);
                mem_l0_k1[i] <= 20'h80000 | PIX_W'(i);
                mem_l1_k0[i] <= 20'h80000 | PIX_W'(i);
                mem_l1_k1[i] <= 20'h80000 | PIX_W'(i);
            end
        end else if (cwr) begin
            case (csel)
                SEL_L0_K0: mem_l0_k0[caddr_wr[AW-1:0]] <= cdata_wr;
                SEL_L0_K1: mem_l0_k1[caddr_wr[AW-1:0]] <= cdata_wr;
                SEL_L1_K0: mem_l1_k0[caddr_wr[AW-1:0]] <= cdata_wr;
                SEL_L1_K1: mem_l1_k1[caddr_wr[AW-1:0]] <= cdata_wr;
                default: ;
            endcase
        end
    end

    // port rules, sampled away from the clock edge
    always @(negedge clk) begin
        if (!rst) begin
            assert (!(cwr && crd)) else begin
                $display("read and write strobes both high at %0t", $time);
                port_errors++;
            end
            assert (csel <= SEL_L1_K1) else begin
                $display("memory select %0d out of range at %0t", csel, $time);
                port_errors++;
            end
            assert (busy || !cwr) else begin
                $display("memory write while not busy at %0t", $time);
                port_errors++;
            end
        end
    end

    // **********************************************************************
    // reference model
    // **********************************************************************
    task automatic fill_rom(input test_row_t row);
        int   r;
        int   c;
        pix_t v;
        for (r = 0; r < SIDE; r++) begin
            for (c = 0; c < SIDE; c++) begin
                case (row.kind)
                    PAT_ZERO:  v = '0;
                    PAT_CONST: v = row.fill;
                    PAT_RAND:  v = pix_t'($random(seed)) >>> 2;   // roughly +-2.0
                    default:   v = ((r + c) % 2 == 1) ? row.fill : -row.fill;
                endcase
                rom[r * SIDE + c] = v;
            end
        end
    endtask

    function automatic pix_t conv_ref(input int k, input int r, input int c);
        longint acc;
        int     t;
        int     nr;
        int     nc;
        pix_t   px;
        acc = 0;
        for (t = 0; t < NUM_TAPS; t++) begin
            nr = r + t / 3 - 1;
            nc = c + t % 3 - 1;
            if (nr < 0 || nr >= SIDE || nc < 0 || nc >= SIDE)
                px = '0;   // zero padding
            else
                px = rom[nr * SIDE + nc];
            acc += longint'(px) * longint'(KERNEL_W[k][t]);
        end
        acc += longint'(KERNEL_BIAS[k]) <<< FRAC_W;
        // back to 4.16, plus the first dropped bit
        return pix_t'(acc >>> FRAC_W) + pix_t'((acc >>> (FRAC_W - 1)) & 1);
    endfunction

    function automatic pix_t relu(input pix_t v);
        return (v < 0) ? '0 : v;
    endfunction

    task automatic build_expected();
        int   r;
        int   c;
        int   br;
        int   bc;
        int   idx;
        pix_t m0;
        pix_t m1;
        for (r = 0; r < SIDE; r++) begin
            for (c = 0; c < SIDE; c++) begin
                exp_k0[r * SIDE + c] = relu(conv_ref(0, r, c));
                exp_k1[r * SIDE + c] = relu(conv_ref(1, r, c));
            end
        end
        for (br = 0; br < HALF; br++) begin
            for (bc = 0; bc < HALF; bc++) begin
                m0 = exp_k0[2 * br * SIDE + 2 * bc];
                m1 = exp_k1[2 * br * SIDE + 2 * bc];
                for (r = 2 * br; r < 2 * br + 2; r++) begin
                    for (c = 2 * bc; c < 2 * bc + 2; c++) begin
                        idx = r * SIDE + c;
                        if (exp_k0[idx] > m0) m0 = exp_k0[idx];
                        if (exp_k1[idx] > m1) m1 = exp_k1[idx];
                    end
                end
                exp_p0[br * HALF + bc] = m0;
                exp_p1[br * HALF + bc] = m1;
            end
        end
    endtask

    // **********************************************************************
    // checks and sequencing
    // **********************************************************************
    task automatic check_results(input test_row_t row, output int mism);
        int i;
        mism = 0;
        for (i = 0; i < NPIX; i++) begin
            assert (mem_l0_k0[i] == exp_k0[i]) else begin
                $display("FAIL %0t: memory 1 [%0d] is %h, expected %h",
                         $time, i, mem_l0_k0[i], exp_k0[i]);
                mism++;
            end
            assert (mem_l0_k1[i] == exp_k1[i]) else begin
                $display("FAIL %0t: memory 2 [%0d] is %h, expected %h",
                         $time, i, mem_l0_k1[i], exp_k1[i]);
                mism++;
            end
        end
        for (i = 0; i < NPOOL; i++) begin
            assert (mem_l1_k0[i] == exp_p0[i]) else begin
                $display("FAIL %0t: memory 3 [%0d] is %h, expected %h",
                         $time, i, mem_l1_k0[i], exp_p0[i]);
                mism++;
            end
            assert (mem_l1_k1[i] == exp_p1[i]) else begin
                $display("FAIL %0t: memory 4 [%0d] is %h, expected %h",
                         $time, i, mem_l1_k1[i], exp_p1[i]);
                mism++;
            end
        end
        // blank image leaves only the biases
        if (row.kind == PAT_ZERO) begin
            for (i = 0; i < NPIX; i++) begin
                assert (mem_l0_k0[i] == KERNEL_BIAS[0] && mem_l0_k1[i] == '0) else begin
                    $display("FAIL %0t: blank image entry %0d is %h / %h",
                             $time, i, mem_l0_k0[i], mem_l0_k1[i]);
                    mism++;
                end
            end
        end
    endtask

    task automatic wait_busy(input logic level, input int limit, output logic ok);
        int n;
        n = 0;
        while (busy !== level && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        ok = (busy === level);
    endtask

    task automatic run_test(input int idx);
        test_row_t row;
        int        mism;
        int        data_mism;
        int        port_before;
        logic      ok;
        row         = TESTS[idx];
        mism        = 0;
        data_mism   = 0;
        port_before = port_errors;
        fill_rom(row);
        build_expected();
        @(posedge clk);
        #1 clear_mem = 1'b1;
        @(posedge clk);
        #1 clear_mem = 1'b0;
        assert (busy == 1'b0) else begin
            $display("FAIL %0t: busy is high before start", $time);
            mism++;
        end
        ready = 1'b1;
        @(posedge clk);
        #1 ready = 1'b0;
        wait_busy(1'b1, 4, ok);
        if (!ok) begin
            $display("busy did not rise after ready in test %0d", idx);
            timed_out = 1'b1;
        end else begin
            wait_busy(1'b0, BUSY_TIMEOUT, ok);
            if (!ok) begin
                $display("busy did not fall within %0d cycles in test %0d", BUSY_TIMEOUT, idx);
                timed_out = 1'b1;
            end
        end
        if (!timed_out) begin
            repeat (4) @(posedge clk);   // idle port stays quiet
            check_results(row, data_mism);
        end
        mism += data_mism + port_errors - port_before;
        errors += mism;
        tests_run++;
        if (mism == 0 && !timed_out) begin
            $display("test %0d (pattern %0d, fill %h): ok", idx, row.kind, row.fill);
        end else begin
            $display("test %0d (pattern %0d, fill %h): %0d errors%s", idx, row.kind,
                     row.fill, mism, timed_out ? ", timed out" : "");
            failed_tests++;
        end
    endtask

    initial begin : main
        int i;
        int t;
        rst          = 1'b1;
        ready        = 1'b0;
        clear_mem    = 1'b0;
        timed_out    = 1'b0;
        seed         = 10;
        errors       = 0;
        port_errors  = 0;
        failed_tests = 0;
        tests_run    = 0;
        for (i = 0; i < NPIX; i++)
            rom[i] = '0;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        assert (!busy && !cwr && !crd && csel == SEL_NONE) else begin
            $display("FAIL %0t: port not idle after reset", $time);
            errors++;
        end
        for (t = 0; t < NUM_TESTS && !timed_out; t++)
            run_test(t);
        $display("tests run %0d, failed %0d, errors %0d", tests_run, failed_tests, errors);
        if (errors == 0 && port_errors == 0 && failed_tests == 0 && !timed_out) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* conv.f */
verilog/conv_pkg.sv
verilog/window_fetch.sv
verilog/conv_mac.sv
verilog/max_pool.sv
verilog/layer_ctrl.sv
verilog/conv_top.sv
dv/conv_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f conv.f --top-module conv_tb -o conv_sim
	./obj_dir/conv_sim | tee /dev/stderr | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
